// ==== sim.f ====
src/icache_pkg.sv
src/fetch_unit.sv
src/icache.sv
src/boot_ram.sv
src/fetch_top.sv
dv/fetch_tb.sv

// ==== Makefile ====
# Verilator simulation of the instruction fetch path

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TESTBENCH PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Result is taken from the simulator output, not its exit status
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/fetch_tb.sv ====
// Instruction fetch path testbench
`timescale 1ns/1ps

module fetch_tb
   import icache_pkg::*;
   ();

   localparam int                CWIDTH   = 6;
   localparam logic [IWB_AW-1:0] RESET_PC = '0;
   localparam int                SEED     = 3888;
   // Program area and test lengths in words
   localparam int PROG_WORDS   = 256;
   localparam int N_COLD       = 64;
   localparam int LOOP_PC      = 64;
   localparam int N_LOOP       = 32;
   localparam int N_BP         = 100;
   localparam int N_PRE_JUMP   = 5;
   localparam int JUMP_PC      = 32;
   localparam int N_JUMP       = 20;
   localparam int N_REPROG     = 16;
   localparam int TOTAL_FETCH  = N_COLD + N_LOOP + N_BP + N_PRE_JUMP + N_JUMP + N_REPROG;
   // Four cycles per fetch, plus program load and slack
   localparam int WATCHDOG_CYC = TOTAL_FETCH * 4 + PROG_WORDS + N_REPROG + 500;

   logic              wb_clk_i;
   logic              wb_rst_i;
   logic              run_i;
   logic              jump_i;
   logic [IWB_AW-1:0] jump_pc_i;
   logic              flush_i;
   prog_wr_t          prog_wr_i;
   fetch_out_t        insn_o;
   logic              insn_valid_o;
   logic              insn_ready_i;

   // Program model, one entry per RAM word
   logic [INSN_W-1:0] prog_mem [1 << (IWB_AW-2)];
   // Checker state
   logic [IWB_AW-1:0] exp_pc     = RESET_PC;
   int                accept_cnt = 0;
   logic              held_q     = 1'b0;
   fetch_out_t        held_val;

   fetch_top #(.CWIDTH(CWIDTH), .RESET_PC(RESET_PC)) fetch_top_inst
     (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .run_i(run_i), .jump_i(jump_i), .jump_pc_i(jump_pc_i),
      .flush_i(flush_i), .prog_wr_i(prog_wr_i),
      .insn_o(insn_o), .insn_valid_o(insn_valid_o), .insn_ready_i(insn_ready_i));

   // 100 ns clock
   initial wb_clk_i = 1'b0;
   always #50 wb_clk_i = ~wb_clk_i;

   //////////////////////////////
   // Reference and compare

   // Expected instruction for a pc, straight from the model
   function automatic fetch_out_t ref_fetch(input logic [IWB_AW-1:0] pc);
      fetch_out_t res;
      res.pc   = pc;
      res.insn = prog_mem[pc[IWB_AW-1:2]];
      return res;
   endfunction

   task automatic report_failure();
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_out(input string name, input fetch_out_t exp, input fetch_out_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s expected pc=%h insn=%h actual pc=%h insn=%h",
                  $time, name, exp.pc, exp.insn, act.pc, act.insn);
         report_failure();
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp)
      begin
         $display("ERR %0t %s expected count %0d actual %0d", $time, name, exp, act);
         report_failure();
      end
   endtask

   // Outputs are stable at the falling edge
   always @(negedge wb_clk_i)
   begin
      if (!wb_rst_i)
      begin
         // Word waiting under back-pressure must stay put
         if (held_q)
         begin
            if (insn_valid_o !== 1'b1)
            begin
               $display("Held instruction at pc %h was lost before transfer", held_val.pc);
               report_failure();
            end
            check_out("insn_o held", held_val, insn_o);
         end
         if (insn_valid_o && insn_ready_i)
         begin
            check_out("insn_o", ref_fetch(exp_pc), insn_o);
            exp_pc     = exp_pc + IWB_AW'(4);
            accept_cnt = accept_cnt + 1;
         end
         held_q   = insn_valid_o && !insn_ready_i && !jump_i;
         held_val = insn_o;
         // Sequence restarts at the target after a jump
         if (jump_i)
            exp_pc = jump_pc_i;
      end
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_CYC * 100);
      $display("Timeout, the fetch stream stalled after %0d instructions", accept_cnt);
      report_failure();
   end

   //////////////////////////////
   // Stimulus helpers

   task automatic next_cycle();
      @(posedge wb_clk_i);
      #5;
   endtask

   task automatic write_program(input int first, input int count);
      logic [INSN_W-1:0] word;
      for (int w = first; w < first + count; w++)
      begin
         word        = $urandom();
         prog_wr_i   = '{we: 1'b1, adr: (IWB_AW-2)'(w), dat: word};
         prog_mem[w] = word;
         next_cycle();
      end
      prog_wr_i = '0;
   endtask

   task automatic pulse_flush();
      flush_i = 1'b1;
      next_cycle();
      flush_i = 1'b0;
   endtask

   task automatic pulse_jump(input logic [IWB_AW-1:0] pc);
      jump_pc_i = pc;
      jump_i    = 1'b1;
      next_cycle();
      jump_i    = 1'b0;
   endtask

   // Run until n more transfers, ready either high or random
   task automatic pass_accepts(input int n, input logic random_ready);
      int target;
      target = accept_cnt + n;
      while (accept_cnt < target)
      begin
         insn_ready_i = random_ready ? (($urandom() & 1) != 0) : 1'b1;
         next_cycle();
      end
      insn_ready_i = 1'b1;
   endtask

   // Stop fetching and wait for a quiet output
   task automatic drain_output();
      int quiet;
      quiet        = 0;
      run_i        = 1'b0;
      insn_ready_i = 1'b1;
      while (quiet < 3)
      begin
         next_cycle();
         quiet = insn_valid_o ? 0 : quiet + 1;
      end
   endtask

   // Valid must stay high for a whole cached range
   task automatic count_valid_run(input int n);
      int cnt;
      cnt = 0;
      @(negedge wb_clk_i);
      while (!insn_valid_o)
         @(negedge wb_clk_i);
      repeat (n)
      begin
         if (insn_valid_o)
            cnt = cnt + 1;
         @(negedge wb_clk_i);
      end
      check_count("insn_valid_o", n, cnt);
      next_cycle();
   endtask

   //////////////////////////////
   // Test sequence
   initial
   begin
      void'($urandom(SEED));
      wb_rst_i     = 1'b1;
      run_i        = 1'b0;
      jump_i       = 1'b0;
      jump_pc_i    = '0;
      flush_i      = 1'b0;
      prog_wr_i    = '0;
      insn_ready_i = 1'b0;
      repeat (5)
         next_cycle();
      wb_rst_i = 1'b0;
      if (insn_valid_o !== 1'b0)
      begin
         $display("insn_valid_o is not low after reset");
         report_failure();
      end

      // Cold run from reset pc, every fetch misses
      write_program(0, PROG_WORDS);
      pulse_flush();
      run_i        = 1'b1;
      insn_ready_i = 1'b1;
      pass_accepts(N_COLD, 1'b0);
      drain_output();

      // Loop back into the cached range
      pulse_jump(IWB_AW'(LOOP_PC));
      run_i = 1'b1;
      count_valid_run(N_LOOP);

      // Random back-pressure
      pass_accepts(N_BP, 1'b1);

      // Jump while the stream is busy
      pass_accepts(N_PRE_JUMP, 1'b0);
      pulse_jump(IWB_AW'(JUMP_PC));
      pass_accepts(N_JUMP, 1'b0);

      // New code over cached words, flush before use
      drain_output();
      write_program(JUMP_PC / 4, N_REPROG);
      pulse_flush();
      pulse_jump(IWB_AW'(JUMP_PC));
      run_i = 1'b1;
      pass_accepts(N_REPROG, 1'b0);
      drain_output();

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// ==== src/fetch_top.sv ====
// Instruction fetch path top
`timescale 1ns/1ps

module fetch_top
   import icache_pkg::*;
   #(parameter int                CWIDTH   = 6,
     parameter logic [IWB_AW-1:0] RESET_PC = '0)
   (input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              run_i,
    input  logic              jump_i,
    input  logic [IWB_AW-1:0] jump_pc_i,
    input  logic              flush_i,
    input  prog_wr_t          prog_wr_i,
    output fetch_out_t        insn_o,
    output logic              insn_valid_o,
    input  logic              insn_ready_i);

   // Instruction bus and refill path
   iwb_req_t          iwb_req;
   iwb_rsp_t          iwb_rsp;
   ram_req_t          ram_req;
   logic [INSN_W-1:0] ram_dat;

   // Master side
   fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_inst
     (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .run_i(run_i), .jump_i(jump_i), .jump_pc_i(jump_pc_i),
      .iwb_req_o(iwb_req), .iwb_rsp_i(iwb_rsp),
      .insn_o(insn_o), .insn_valid_o(insn_valid_o), .insn_ready_i(insn_ready_i));

   // Cache between fetch and RAM
   icache #(.CWIDTH(CWIDTH)) icache_inst
     (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .iwb_req_i(iwb_req), .iwb_rsp_o(iwb_rsp),
      .ram_req_o(ram_req), .ram_dat_i(ram_dat),
      .flush_i(flush_i));

   // Program store
   boot_ram boot_ram_inst
     (.wb_clk_i(wb_clk_i),
      .ram_req_i(ram_req), .ram_dat_o(ram_dat),
      .prog_wr_i(prog_wr_i));

endmodule

// ==== src/boot_ram.sv ====
// Program block RAM
`timescale 1ns/1ps

module boot_ram
   import icache_pkg::*;
   (input  logic              wb_clk_i,
    input  ram_req_t          ram_req_i,
    output logic [INSN_W-1:0] ram_dat_o,
    input  prog_wr_t          prog_wr_i);

   // One word per 4 bytes of bus address space
   localparam int DEPTH = 1 << (IWB_AW - 2);

   logic [INSN_W-1:0] mem [DEPTH];
   logic [IWB_AW-3:0] rd_adr;

   // Drop byte offset
   assign rd_adr = ram_req_i.adr[IWB_AW-1:2];

   //////////////////////////////
   // Program load port
   always_ff @(posedge wb_clk_i)
   begin
      if (prog_wr_i.we)
         mem[prog_wr_i.adr] <= prog_wr_i.dat;
   end

   //////////////////////////////
   // Cache read port
   // Data valid one cycle after the address
   // Read of a word being written returns the old value
   always_ff @(posedge wb_clk_i)
   begin
      if (ram_req_i.en)
         ram_dat_o <= mem[rd_adr];
   end

endmodule

// ==== src/icache.sv ====
// Direct-mapped instruction cache
`timescale 1ns/1ps

module icache
   import icache_pkg::*;
   #(parameter int CWIDTH = 6)
   (input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  iwb_req_t          iwb_req_i,
    output iwb_rsp_t          iwb_rsp_o,
    output ram_req_t          ram_req_o,
    input  logic [INSN_W-1:0] ram_dat_i,
    input  logic              flush_i);

   localparam int NLINES = 1 << CWIDTH;
   localparam int TAGW   = IWB_AW - CWIDTH - 2;

   // Line storage
   logic [INSN_W-1:0] data_mem [NLINES];
   logic [TAGW-1:0]   tag_mem  [NLINES];
   logic [NLINES-1:0] valid_q;

   logic [CWIDTH-1:0] line;
   logic [TAGW-1:0]   tag;
   logic              hit;
   logic              fwd_ok;
   logic              ack;
   logic              store;
   logic              stb_d1;
   logic              ack_d1;

   //////////////////////////////
   // Lookup
   // Index just above the byte offset
   // Tag is the rest of the address
   assign line = iwb_req_i.adr[CWIDTH+1:2];
   assign tag  = iwb_req_i.adr[IWB_AW-1:CWIDTH+2];
   assign hit  = valid_q[line] & (tag_mem[line] == tag);

   //////////////////////////////
   // Ack and forwarding
   // RAM word is ready one cycle after stb
   // Previous ack blocks a second one for the same address
   assign fwd_ok = stb_d1 & ~ack_d1;
   assign ack    = iwb_req_i.stb & (hit | fwd_ok);
   // Miss data comes straight from RAM
   assign iwb_rsp_o = '{dat: hit ? data_mem[line] : ram_dat_i, ack: ack};

   // RAM always follows the bus address on the single port
   assign ram_req_o = '{adr: iwb_req_i.adr, en: iwb_req_i.stb};

   // Refill the line in the same cycle the forwarded word is acked
   assign store = iwb_req_i.stb & fwd_ok;

   //////////////////////////////
   // Arrays
   always_ff @(posedge wb_clk_i)
   begin
      if (wb_rst_i | flush_i)
         valid_q <= '0;
      else if (store)
         valid_q[line] <= 1'b1;
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (store)
      begin
         data_mem[line] <= ram_dat_i;
         tag_mem[line]  <= tag;
      end
   end

   // One cycle history for the RAM latency
   always_ff @(posedge wb_clk_i)
   begin
      if (wb_rst_i)
      begin
         stb_d1 <= 1'b0;
         ack_d1 <= 1'b0;
      end
      else
      begin
         stb_d1 <= iwb_req_i.stb;
         ack_d1 <= ack;
      end
   end

   // Ack only under stb
   // A forwarded word must belong to the address held from the cycle before
   a_ack_stb : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      iwb_rsp_o.ack |-> iwb_req_i.stb && (hit || $stable(iwb_req_i.adr)));

   // Held miss gets exactly one forwarded ack
   a_no_double : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      ack && !hit |=> !(ack && !hit && $stable(iwb_req_i.adr)));

endmodule

// ==== src/fetch_unit.sv ====
// Program counter and fetch master
`timescale 1ns/1ps

module fetch_unit
   import icache_pkg::*;
   #(parameter logic [IWB_AW-1:0] RESET_PC = '0)
   (input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              run_i,
    input  logic              jump_i,
    input  logic [IWB_AW-1:0] jump_pc_i,
    output iwb_req_t          iwb_req_o,
    input  iwb_rsp_t          iwb_rsp_i,
    output fetch_out_t        insn_o,
    output logic              insn_valid_o,
    input  logic              insn_ready_i);

   logic [IWB_AW-1:0] pc_q;
   logic [IWB_AW-1:0] jump_tgt_q;
   logic [IWB_AW-1:0] jump_dst;
   logic              jump_pend_q;
   logic              jump_now;
   logic              busy_q;
   logic              start;
   logic              stb;
   logic              ack;
   logic              load;
   fetch_out_t        out_q;
   logic              out_valid_q;

   //////////////////////////////
   // Bus request
   assign ack = iwb_rsp_i.ack;
   // New transfer only if the output register is free or draining now
   // A miss then always finds the register empty at its ack
   assign start = run_i & ~busy_q & ~jump_i & (~out_valid_q | insn_ready_i);
   // An unfinished transfer keeps stb up regardless of run or ready
   assign stb = busy_q | start;
   assign iwb_req_o = '{adr: pc_q, stb: stb};

   // Jump target, forced to a word boundary
   assign jump_now = jump_i | jump_pend_q;
   assign jump_dst = jump_i ? {jump_pc_i[IWB_AW-1:2], 2'b00} : jump_tgt_q;
   // Words acked around a jump are dropped
   assign load = ack & ~jump_now;

   always_ff @(posedge wb_clk_i)
   begin
      if (wb_rst_i)
      begin
         pc_q        <= RESET_PC;
         jump_pend_q <= 1'b0;
         busy_q      <= 1'b0;
      end
      else
      begin
         busy_q <= stb & ~ack;
         // Take the target once nothing is left in flight
         if (jump_now && !(stb && !ack))
         begin
            pc_q        <= jump_dst;
            jump_pend_q <= 1'b0;
         end
         else if (jump_i)
            jump_pend_q <= 1'b1;
         else if (ack)
            pc_q <= pc_q + IWB_AW'(4);
      end
   end

   // Target held until the open transfer ends
   always_ff @(posedge wb_clk_i)
   begin
      if (jump_i)
         jump_tgt_q <= {jump_pc_i[IWB_AW-1:2], 2'b00};
   end

   //////////////////////////////
   // Output register
   always_ff @(posedge wb_clk_i)
   begin
      if (wb_rst_i)
         out_valid_q <= 1'b0;
      else if (load)
         out_valid_q <= 1'b1;
      else if (jump_i | insn_ready_i)
         out_valid_q <= 1'b0;
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (load)
         out_q <= '{pc: pc_q, insn: iwb_rsp_i.dat};
   end

   assign insn_o       = out_q;
   assign insn_valid_o = out_valid_q;

   // Wishbone classic, address held while waiting for ack
   a_adr_held : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      iwb_req_o.stb && !ack |=> iwb_req_o.stb && $stable(iwb_req_o.adr));

endmodule

// ==== src/icache_pkg.sv ====
// Instruction fetch shared types
package icache_pkg;

   // Byte address width of the instruction bus
   localparam int IWB_AW = 14;

   // Instruction word width
   localparam int INSN_W = 32;

   //////////////////////////////
   // Instruction bus halves

   // Master to slave
   typedef struct packed {
      logic [IWB_AW-1:0] adr;
      logic              stb;
   } iwb_req_t;

   // Slave to master
   typedef struct packed {
      logic [INSN_W-1:0] dat;
      logic              ack;
   } iwb_rsp_t;

   //////////////////////////////
   // Cache refill and program load

   // Byte address, word aligned
   typedef struct packed {
      logic [IWB_AW-1:0] adr;
      logic              en;
   } ram_req_t;

   // Word address here, not byte address
   typedef struct packed {
      logic              we;
      logic [IWB_AW-3:0] adr;
      logic [INSN_W-1:0] dat;
   } prog_wr_t;

   // One fetched instruction with its address
   typedef struct packed {
      logic [IWB_AW-1:0] pc;
      logic [INSN_W-1:0] insn;
   } fetch_out_t;

endpackage
